// ==== hw/dcache_pkg.sv ====
// Shared widths, address layout, store and lookup types for the data cache blocks.
package dcache_pkg;

    // ------------------------------------------------------------------------
    // Geometry.
    // ------------------------------------------------------------------------
    localparam int ADDR_W         = 64;
    localparam int XLEN           = 64;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 16;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
    localparam int SETS           = 256;
    localparam int WAYS           = 4;

    // Address fields.
    localparam int OFFSET_W = $clog2(WORDS_PER_LINE);
    localparam int INDEX_W  = $clog2(SETS);
    localparam int BYTE_W   = $clog2(WORD_W / 8);
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W - BYTE_W;

    // LRU age, one per way.
    localparam int AGE_W = $clog2(WAYS);

    // ------------------------------------------------------------------------
    // Types.
    // ------------------------------------------------------------------------
    typedef logic [$clog2(WAYS)-1:0] way_t;
    typedef logic [LINE_W-1:0]       line_t;
    typedef logic [TAG_W-1:0]        tag_t;

    typedef struct packed {
        tag_t                tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
        logic [BYTE_W-1:0]   byte_sel;
    } dcache_addr_t;

    typedef enum logic [1:0] {
        SB = 2'd0,
        SH = 2'd1,
        SW = 2'd2,
        SD = 2'd3
    } store_size_e;

    typedef struct packed {
        logic              en;
        store_size_e       size;
        logic [XLEN-1:0]   data;
    } store_t;

    // Selected way is the hit way on a hit, the victim otherwise.
    typedef struct packed {
        logic hit;
        way_t hit_way;
        way_t sel_way;
        logic dirty;
    } lookup_t;

endpackage

// ==== hw/dcache_set_ram.sv ====
// Set by way storage array, written at one way of a set and read across all ways of a set.
module dcache_set_ram
    import dcache_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic               clk,
    input  logic               i_we,
    input  logic [INDEX_W-1:0] i_index,
    input  way_t               i_way,
    input  payload_t           i_wdata,
    output payload_t           o_rdata [WAYS]
);

    // ------------------------------------------------------------------------
    // Storage.
    // ------------------------------------------------------------------------
    payload_t mem [SETS][WAYS];

    // One way written per cycle.
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_index][i_way] <= i_wdata;
        end
    end

    // All ways of the addressed set, combinational.
    assign o_rdata = mem[i_index];

endmodule

// ==== hw/dcache_tag_array.sv ====
// Tag, valid and dirty state of the cache; does the four-way compare and picks the selected way.
module dcache_tag_array
    import dcache_pkg::*;
(
    input  logic               clk,
    input  logic               arstn,
    input  tag_t               i_tag,
    input  logic [INDEX_W-1:0] i_index,
    input  way_t               i_victim,
    input  logic               i_store_en,
    input  logic               i_refill_en,
    output lookup_t            o_lookup
);

    tag_t              tag_rd [WAYS];
    logic [WAYS-1:0]   hit_vec;
    way_t              hit_way;
    way_t              sel_way;
    logic              tag_we;

    logic [SETS-1:0][WAYS-1:0] valid_q;
    logic [SETS-1:0][WAYS-1:0] dirty_q;

    // Store wins over refill.
    assign tag_we = i_refill_en & ~i_store_en;

    dcache_set_ram #(
        .payload_t (tag_t)
    ) tag_ram_inst (
        .clk     (clk),
        .i_we    (tag_we),
        .i_index (i_index),
        .i_way   (sel_way),
        .i_wdata (i_tag),
        .o_rdata (tag_rd)
    );

    // ------------------------------------------------------------------------
    // Compare.
    // ------------------------------------------------------------------------
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = valid_q[i_index][w] & (tag_rd[w] == i_tag);
            if (hit_vec[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign sel_way = (|hit_vec) ? hit_way : i_victim;

    assign o_lookup.hit     = |hit_vec;
    assign o_lookup.hit_way = hit_way;
    assign o_lookup.sel_way = sel_way;
    assign o_lookup.dirty   = dirty_q[i_index][sel_way];

    // ------------------------------------------------------------------------
    // Line state.
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_store_en) begin
            dirty_q[i_index][sel_way] <= 1'b1;
        end else if (i_refill_en) begin
            // Fresh line from memory.
            valid_q[i_index][sel_way] <= 1'b1;
            dirty_q[i_index][sel_way] <= 1'b0;
        end
    end

endmodule

// ==== hw/dcache_lru.sv ====
// Per-set LRU ages; reports the age-zero way as victim and promotes the hit way on update.
module dcache_lru
    import dcache_pkg::*;
(
    input  logic               clk,
    input  logic               arstn,
    input  logic [INDEX_W-1:0] i_index,
    input  lookup_t            i_lookup,
    input  logic               i_lru_update,
    output way_t               o_victim
);

    localparam logic [AGE_W-1:0] AGE_MRU = AGE_W'(WAYS - 1);

    logic [SETS-1:0][WAYS-1:0][AGE_W-1:0] age_q;
    logic [WAYS-1:0][AGE_W-1:0]           set_ages;
    logic [AGE_W-1:0]                     hit_age;
    way_t                                 victim;

    assign set_ages = age_q[i_index];
    assign hit_age  = set_ages[i_lookup.hit_way];

    // ------------------------------------------------------------------------
    // Victim.
    // ------------------------------------------------------------------------
    always_comb begin
        victim = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (set_ages[w] == '0) begin
                victim = way_t'(w);
            end
        end
    end

    assign o_victim = victim;

    // ------------------------------------------------------------------------
    // Age update.
    // ------------------------------------------------------------------------

    // Ages start as 0..3 in way order, so way 0 goes first.
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    age_q[s][w] <= AGE_W'(w);
                end
            end
        end else if (i_lru_update && i_lookup.hit) begin
            for (int w = 0; w < WAYS; w++) begin
                if (way_t'(w) == i_lookup.hit_way) begin
                    age_q[i_index][w] <= AGE_MRU;
                end else if (set_ages[w] > hit_age) begin
                    age_q[i_index][w] <= set_ages[w] - 1'b1;
                end
            end
        end
    end

endmodule

// ==== hw/dcache_data_array.sv ====
// Line storage of the cache; merges stores, writes refills and reads 64 bits at a word offset.
module dcache_data_array
    import dcache_pkg::*;
(
    input  logic                clk,
    input  logic [INDEX_W-1:0]  i_index,
    input  logic [OFFSET_W-1:0] i_offset,
    input  lookup_t             i_lookup,
    input  store_t              i_store,
    input  logic                i_refill_en,
    input  line_t               i_refill_line,
    output logic [XLEN-1:0]     o_data,
    output line_t               o_line
);

    line_t                       line_rd [WAYS];
    line_t                       sel_line;
    line_t                       store_bits;
    line_t                       bit_mask;
    line_t                       merged;
    line_t                       wdata;
    logic                        we;
    logic [7:0]                  size_bytes;
    logic [LINE_W/8-1:0]         byte_mask;
    logic [LINE_W+XLEN-1:0]      read_window;

    assign sel_line = line_rd[i_lookup.sel_way];

    // ------------------------------------------------------------------------
    // Store merge.
    // ------------------------------------------------------------------------
    always_comb begin
        case (i_store.size)
            SB:      size_bytes = 8'h01;
            SH:      size_bytes = 8'h03;
            SW:      size_bytes = 8'h0f;
            default: size_bytes = 8'hff;
        endcase
    end

    // Shifting into a line-wide vector drops bytes past the end.
    always_comb begin
        byte_mask  = {{(LINE_W / 8 - 8){1'b0}}, size_bytes} << (i_offset * (WORD_W / 8));
        store_bits = {{(LINE_W - XLEN){1'b0}}, i_store.data} << (i_offset * WORD_W);
        for (int b = 0; b < LINE_W / 8; b++) begin
            bit_mask[b*8 +: 8] = {8{byte_mask[b]}};
        end
        merged = (sel_line & ~bit_mask) | (store_bits & bit_mask);
    end

    // Store has priority over refill.
    assign we    = i_store.en | i_refill_en;
    assign wdata = i_store.en ? merged : i_refill_line;

    dcache_set_ram #(
        .payload_t (line_t)
    ) line_ram_inst (
        .clk     (clk),
        .i_we    (we),
        .i_index (i_index),
        .i_way   (i_lookup.sel_way),
        .i_wdata (wdata),
        .o_rdata (line_rd)
    );

    // ------------------------------------------------------------------------
    // Read.
    // ------------------------------------------------------------------------

    // Zeros above the line fill the top half at offset 15.
    assign read_window = {{XLEN{1'b0}}, sel_line} >> (i_offset * WORD_W);
    assign o_data      = read_window[XLEN-1:0];

    // Whole line for write-back.
    assign o_line = sel_line;

endmodule

// ==== hw/dcache_top.sv ====
// Data cache top level: splits the address and connects tag array, LRU tracker and data array.
module dcache_top
    import dcache_pkg::*;
(
    input  logic            clk,
    input  logic            arstn,
    input  dcache_addr_t    i_addr,
    input  store_t          i_store,
    input  logic            i_refill_en,
    input  line_t           i_refill_line,
    input  logic            i_lru_update,
    output logic            o_hit,
    output logic [XLEN-1:0] o_data,
    output logic            o_dirty,
    output line_t           o_line
);

    tag_t                tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
    lookup_t             lookup;
    way_t                victim;

    // ------------------------------------------------------------------------
    // Address split.
    // ------------------------------------------------------------------------
    assign tag    = i_addr.tag;
    assign index  = i_addr.index;
    assign offset = i_addr.offset;

    // ------------------------------------------------------------------------
    // Tag, valid and dirty state.
    // ------------------------------------------------------------------------
    dcache_tag_array tag_array_inst (
        .clk         (clk),
        .arstn       (arstn),
        .i_tag       (tag),
        .i_index     (index),
        .i_victim    (victim),
        .i_store_en  (i_store.en),
        .i_refill_en (i_refill_en),
        .o_lookup    (lookup)
    );

    // Replacement order.
    dcache_lru lru_inst (
        .clk          (clk),
        .arstn        (arstn),
        .i_index      (index),
        .i_lookup     (lookup),
        .i_lru_update (i_lru_update),
        .o_victim     (victim)
    );

    // ------------------------------------------------------------------------
    // Line data.
    // ------------------------------------------------------------------------
    dcache_data_array data_array_inst (
        .clk           (clk),
        .i_index       (index),
        .i_offset      (offset),
        .i_lookup      (lookup),
        .i_store       (i_store),
        .i_refill_en   (i_refill_en),
        .i_refill_line (i_refill_line),
        .o_data        (o_data),
        .o_line        (o_line)
    );

    assign o_hit   = lookup.hit;
    assign o_dirty = lookup.dirty;

endmodule

// ==== verification/tb_dcache_tasks.svh ====
// Drive, check and directed test tasks, included into the data cache testbench module.
`ifndef TB_DCACHE_TASKS_SVH
`define TB_DCACHE_TASKS_SVH

task automatic check_value(input string name, input line_t got, input line_t exp);
    if (got !== exp) begin
        $display("CHECK FAILED at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        $display("TEST FAILED");
        $fatal(1, "Stopping at the first mismatch.");
    end
endtask

task automatic clear_model();
    for (int s = 0; s < SETS; s++) begin
        for (int w = 0; w < WAYS; w++) begin
            sh_valid[s][w] = 1'b0;
            sh_dirty[s][w] = 1'b0;
            sh_age[s][w]   = AGE_W'(w);
        end
    end
endtask

function automatic tag_t random_tag();
    return tag_t'({$random(seed), $random(seed)});
endfunction

function automatic logic [XLEN-1:0] random_data();
    return {$random(seed), $random(seed)};
endfunction

function automatic line_t random_line();
    line_t l;
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
        l[i*WORD_W +: WORD_W] = $random(seed);
    end
    return l;
endfunction

// One access: drive on the rising edge, check at the falling edge, then update the model.
task automatic run_cycle(input tag_t t, input int idx, input int off, input logic st_en,
                         input store_size_e sz, input logic [XLEN-1:0] d,
                         input logic rf_en, input line_t rf_line, input logic upd);
    dcache_addr_t     a;
    store_t           st;
    int               hw;
    int               sel;
    logic [AGE_W-1:0] old_age;
    a.tag      = t;
    a.index    = INDEX_W'(idx);
    a.offset   = OFFSET_W'(off);
    a.byte_sel = '0;
    st.en      = st_en;
    st.size    = sz;
    st.data    = d;
    @(posedge clk);
    addr        <= a;
    store       <= st;
    refill_en   <= rf_en;
    refill_line <= rf_line;
    lru_update  <= upd;
    @(negedge clk);
    hw  = find_way(t, idx);
    sel = (hw >= 0) ? hw : victim_way(idx);
    check_value("o_hit", hit, hw >= 0);
    check_value("o_dirty", dirty, sh_dirty[idx][sel]);
    if (hw >= 0) begin
        check_value("o_data", rdata, expected_word(sh_line[idx][hw], off));
    end
    if (sh_valid[idx][sel]) begin
        check_value("o_line", wb_line, sh_line[idx][sel]);
    end
    if (st_en && hw < 0) begin
        $display("Store issued to a line that is not in the cache at %0d ns.", $time);
        $display("TEST FAILED");
        $fatal(1, "Bad test sequence.");
    end else begin
        if (st_en) begin
            sh_line[idx][hw]  = merge_store(sh_line[idx][hw], off, sz, d);
            sh_dirty[idx][hw] = 1'b1;
        end else if (rf_en) begin
            sh_tag[idx][sel]   = t;
            sh_line[idx][sel]  = rf_line;
            sh_valid[idx][sel] = 1'b1;
            sh_dirty[idx][sel] = 1'b0;
        end
        if (upd && hw >= 0) begin
            old_age = sh_age[idx][hw];
            for (int w = 0; w < WAYS; w++) begin
                if (w == hw) begin
                    sh_age[idx][w] = AGE_W'(WAYS - 1);
                end else if (sh_age[idx][w] > old_age) begin
                    sh_age[idx][w] = sh_age[idx][w] - 1'b1;
                end
            end
        end
    end
endtask

task automatic access(input tag_t t, input int idx, input int off, input logic upd);
    run_cycle(t, idx, off, 1'b0, SB, '0, 1'b0, '0, upd);
endtask

task automatic store_data(input tag_t t, input int idx, input int off,
                          input store_size_e sz, input logic [XLEN-1:0] d);
    run_cycle(t, idx, off, 1'b1, sz, d, 1'b0, '0, 1'b0);
endtask

task automatic fill_line(input tag_t t, input int idx, input line_t l);
    run_cycle(t, idx, 0, 1'b0, SB, '0, 1'b1, l, 1'b0);
endtask

task automatic read_whole_line(input tag_t t, input int idx);
    for (int off = 0; off < WORDS_PER_LINE; off++) begin
        access(t, idx, off, 1'b0);
    end
endtask

// ----------------------------------------------------------------------------
// Directed tests.
// ----------------------------------------------------------------------------
task automatic reset_state_misses();
    for (int i = 0; i < 32; i++) begin
        access(random_tag(), $unsigned($random(seed)) % SETS,
               $unsigned($random(seed)) % WORDS_PER_LINE, 1'b0);
    end
endtask

task automatic refill_then_read();
    tag_a = random_tag();
    access(tag_a, set_a, 0, 1'b0);
    fill_line(tag_a, set_a, random_line());
    read_whole_line(tag_a, set_a);
endtask

// Mixed sizes, clipped doubleword at the last word.
task automatic stores_merge();
    int          offs  [6] = '{3, 7, 0, 9, 15, 15};
    store_size_e sizes [6] = '{SB, SH, SW, SD, SD, SH};
    for (int i = 0; i < 6; i++) begin
        store_data(tag_a, set_a, offs[i], sizes[i], random_data());
        read_whole_line(tag_a, set_a);
    end
endtask

task automatic lru_eviction();
    for (int w = 0; w < WAYS; w++) begin
        lru_tags[w] = random_tag();
        fill_line(lru_tags[w], set_b, random_line());
        access(lru_tags[w], set_b, w, 1'b1);
    end
    tag_new = random_tag();
    // Update on a miss leaves the ages alone.
    access(tag_new, set_b, 0, 1'b1);
    store_data(lru_tags[2], set_b, 5, SW, random_data());
    access(lru_tags[2], set_b, 1, 1'b1);
    access(lru_tags[0], set_b, 2, 1'b1);
    access(lru_tags[3], set_b, 3, 1'b1);
    access(lru_tags[1], set_b, 4, 1'b1);
    // Way of lru_tags[2] is now oldest, and it was stored to.
    access(tag_new, set_b, 6, 1'b0);
    check_value("o_dirty", dirty, 1'b1);
endtask

task automatic refill_on_miss();
    fill_line(tag_new, set_b, random_line());
    access(lru_tags[2], set_b, 0, 1'b0);
    check_value("o_hit", hit, 1'b0);
    access(tag_new, set_b, 3, 1'b0);
    check_value("o_hit", hit, 1'b1);
    check_value("o_dirty", dirty, 1'b0);
endtask

`endif

// ==== verification/tb_dcache.sv ====
// Testbench for the data cache top level; runs the directed tests against a shadow model.
module tb_dcache
    import dcache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // Test sequence takes a few hundred cycles.
    localparam int TIMEOUT_CYCLES = 2000;

    logic            clk = 1'b0;
    logic            arstn;
    dcache_addr_t    addr;
    store_t          store;
    logic            refill_en;
    line_t           refill_line;
    logic            lru_update;
    logic            hit;
    logic [XLEN-1:0] rdata;
    logic            dirty;
    line_t           wb_line;

    integer seed = 32'hc3be_eabe;
    int     cycle_count = 0;

    // ------------------------------------------------------------------------
    // Shadow model.
    // ------------------------------------------------------------------------
    tag_t             sh_tag   [SETS][WAYS];
    line_t            sh_line  [SETS][WAYS];
    logic             sh_valid [SETS][WAYS];
    logic             sh_dirty [SETS][WAYS];
    logic [AGE_W-1:0] sh_age   [SETS][WAYS];

    // Test state shared between tests.
    tag_t tag_a;
    int   set_a = 8'h3c;
    int   set_b = 8'ha5;
    tag_t lru_tags [WAYS];
    tag_t tag_new;

    always #2 clk = ~clk;

    dcache_top dcache_top_inst (
        .clk           (clk),
        .arstn         (arstn),
        .i_addr        (addr),
        .i_store       (store),
        .i_refill_en   (refill_en),
        .i_refill_line (refill_line),
        .i_lru_update  (lru_update),
        .o_hit         (hit),
        .o_data        (rdata),
        .o_dirty       (dirty),
        .o_line        (wb_line)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "Timeout.");
        end
    end

    // Way holding a valid copy of the tag, or -1.
    function automatic int find_way(input tag_t t, input int idx);
        for (int w = 0; w < WAYS; w++) begin
            if (sh_valid[idx][w] && sh_tag[idx][w] == t) begin
                return w;
            end
        end
        return -1;
    endfunction

    // Least recent way has age zero.
    function automatic int victim_way(input int idx);
        for (int w = 0; w < WAYS; w++) begin
            if (sh_age[idx][w] == '0) begin
                return w;
            end
        end
        return 0;
    endfunction

    function automatic logic [XLEN-1:0] expected_word(input line_t l, input int off);
        logic [WORD_W-1:0] lo;
        logic [WORD_W-1:0] hi;
        lo = l[off*WORD_W +: WORD_W];
        if (off == WORDS_PER_LINE - 1) begin
            hi = '0;
        end else begin
            hi = l[(off+1)*WORD_W +: WORD_W];
        end
        return {hi, lo};
    endfunction

    // Byte by byte, bytes past the line end are dropped.
    function automatic line_t merge_store(input line_t old_line, input int off,
                                          input store_size_e sz, input logic [XLEN-1:0] d);
        line_t result;
        int    nbytes;
        int    pos;
        result = old_line;
        nbytes = 1 << int'(sz);
        for (int b = 0; b < nbytes; b++) begin
            pos = off * (WORD_W / 8) + b;
            if (pos < LINE_W / 8) begin
                result[pos*8 +: 8] = d[b*8 +: 8];
            end
        end
        return result;
    endfunction

    `include "tb_dcache_tasks.svh"

    initial begin
        arstn       = 1'b0;
        addr        = '0;
        store       = '0;
        refill_en   = 1'b0;
        refill_line = '0;
        lru_update  = 1'b0;
        clear_model();
        repeat (16) @(posedge clk);
        arstn <= 1'b1;

        reset_state_misses();
        refill_then_read();
        stores_merge();
        lru_eviction();
        refill_on_miss();

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+verification
hw/dcache_pkg.sv
hw/dcache_set_ram.sv
hw/dcache_tag_array.sv
hw/dcache_lru.sv
hw/dcache_data_array.sv
hw/dcache_top.sv
verification/tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  # RTL in compile order.
  - hw/dcache_pkg.sv
  - hw/dcache_set_ram.sv
  - hw/dcache_tag_array.sv
  - hw/dcache_lru.sv
  - hw/dcache_data_array.sv
  - hw/dcache_top.sv

  # Testbench.
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_dcache.sv

# Top modules: tb_dcache for simulation, dcache_top for the design.
# File list for simulators: sim.f
#
# Include directory for the testbench tasks is verification.
# Package dcache_pkg must compile first.
